// File: include/layer10_settings.svh
`ifndef LAYER10_SETTINGS_SVH
`define LAYER10_SETTINGS_SVH

// Pixel width.
`define L10_DATA_W 16

// Word address, a 5-bit row followed by a 5-bit column.
`define L10_ADDR_W 10
`define L10_DEPTH 1024

// Stages between the lead coordinates and x_reg5 / y_reg5.
`define L10_COORD_DELAY 5

`endif

// File: verilog/layer10_pkg.sv
`include "layer10_settings.svh"

package layer10_pkg;

	// Scan phase, as selected by the mode input.
	typedef enum logic [2:0] {
		PH_LOAD     = 3'd0, // Tile-by-tile write.
		PH_READ2    = 3'd1, // Column offsets 0 and 8.
		PH_SHIFT    = 3'd2, // All tiles, column shifted by k - 1.
		PH_READ4    = 3'd3, // Column offsets 8, 16, 24 and 0.
		PH_LOAD_ALT = 3'd4  // Same as PH_LOAD.
	} phase_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		PREROLL, // Fills the coordinate delay line.
		SWEEP,
		DONE
	} ctrl_state_t;

	// Position inside an 8x8 tile, also used for L and z.
	typedef logic [2:0] coord_t;

	typedef logic [`L10_ADDR_W-1:0] buf_addr_t;

endpackage

// File: verilog/scan_if.sv
`timescale 1ns/10ps

interface scan_if;
	import layer10_pkg::*;

	coord_t x;
	coord_t y;
	coord_t x_reg5; // x five cycles back.
	coord_t y_reg5;
	coord_t l; // Tile number.
	coord_t z; // Readback step.
	logic [1:0] k;
	phase_t u;

	modport ctrl (
		output x, y, x_reg5, y_reg5, l, z, k, u
	);

	modport agen (
		input x, y, x_reg5, y_reg5, l, z, k, u
	);

endinterface

// File: verilog/bram1_address_l10.sv
`timescale 1ns/10ps

module bram1_address_l10 (
	scan_if.agen s,
	output layer10_pkg::buf_addr_t addr
);
	import layer10_pkg::*;

	logic [4:0] row; // Coordinates widened to the address fields.
	logic [4:0] col;
	logic [4:0] row_reg;
	logic [4:0] col_reg;
	logic [4:0] row_off;
	logic [4:0] col_off;
	logic [4:0] shift_col;

	assign row     = {2'b00, s.x};
	assign col     = {2'b00, s.y};
	assign row_reg = {2'b00, s.x_reg5};
	assign col_reg = {2'b00, s.y_reg5};

	// Tiles 4 to 7 form the lower half of the map.
	assign row_off = s.l[2] ? 5'd8 : 5'd0;
	assign col_off = {s.l[1:0], 3'b000}; // 8 * (L mod 4).

	// Wraps modulo 32 through the 5-bit sum.
	assign shift_col = col + col_off + {3'b000, s.k} - 5'd1;

	always_comb begin
		case (s.u)
			PH_LOAD, PH_LOAD_ALT: begin
				addr = {row + row_off, col + col_off};
			end
			PH_SHIFT: begin
				addr = {row + row_off, shift_col};
			end
			PH_READ2: begin
				case (s.z)
					3'd0:    addr = {row_reg, col_reg};
					3'd1:    addr = {row_reg, col_reg + 5'd8};
					default: addr = '0;
				endcase
			end
			PH_READ4: begin
				// Sequence runs z = 1, 2, 3, 0.
				case (s.z)
					3'd1:    addr = {row_reg, col_reg + 5'd8};
					3'd2:    addr = {row_reg, col_reg + 5'd16};
					3'd3:    addr = {row_reg, col_reg + 5'd24};
					3'd0:    addr = {row_reg, col_reg};
					default: addr = '0;
				endcase
			end
			default: begin
				addr = '0;
			end
		endcase
	end

endmodule

// File: verilog/bram1.sv
`timescale 1ns/10ps
`include "layer10_settings.svh"

module bram1 (
	input  logic                   clk,
	input  logic                   we,
	input  logic                   re,
	input  layer10_pkg::buf_addr_t addr,
	input  logic [`L10_DATA_W-1:0] wdata,
	output logic [`L10_DATA_W-1:0] rdata
);

	logic [`L10_DATA_W-1:0] mem [`L10_DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		// Read register holds its word between reads.
		if (re) begin
			rdata <= we ? wdata : mem[addr]; // New data wins on a shared cycle.
		end
	end

endmodule

// File: verilog/tile_scan_ctrl.sv
`timescale 1ns/10ps
`include "layer10_settings.svh"

module tile_scan_ctrl (
	input  logic                clk,
	input  logic                reset,
	input  logic                start,
	input  logic                pix_valid,
	input  layer10_pkg::phase_t mode,
	input  logic [1:0]          k_in,
	scan_if.ctrl                s,
	output logic                we,
	output logic                re,
	output logic                busy,
	output logic                done,
	output logic                out_valid
);
	import layer10_pkg::*;

	ctrl_state_t state;
	phase_t      u_q; // Phase latched at start.
	logic [1:0]  k_q;
	coord_t      x_q;
	coord_t      y_q;
	coord_t      l_q;
	coord_t      z_q;
	logic [1:0]  lead_q; // Step of the lead coordinate in a readback.
	logic [2:0]  pre_cnt;
	coord_t      x_dly [`L10_COORD_DELAY];
	coord_t      y_dly [`L10_COORD_DELAY];

	logic   readback;
	logic   lead_last;
	logic   adv_xy;
	logic   last_xy;
	logic   sweep_last;
	coord_t z_first;
	coord_t z_last;
	coord_t z_next;

	assign readback  = (u_q == PH_READ2) || (u_q == PH_READ4);
	assign lead_last = (u_q == PH_READ4) ? (lead_q == 2'd3) : (lead_q == 2'd1);
	assign z_first   = (u_q == PH_READ4) ? 3'd1 : 3'd0;
	assign z_last    = (u_q == PH_READ4) ? 3'd0 : 3'd1;
	assign z_next    = (u_q == PH_READ4) ? {1'b0, z_q[1:0] + 2'd1} : {2'b00, ~z_q[0]};

	assign we   = (state == LOAD) && pix_valid;
	assign re   = (state == SWEEP);
	assign busy = (state != IDLE);

	assign last_xy = (l_q == 3'd7) && (x_q == 3'd7) && (y_q == 3'd7);

	// A readback ends on the last step of the last delayed coordinate.
	assign sweep_last = readback ?
		((z_q == z_last) && (s.x_reg5 == 3'd7) && (s.y_reg5 == 3'd7)) : last_xy;

	assign adv_xy = we || (re && !readback) ||
		(readback && lead_last && ((state == PREROLL) || (state == SWEEP)));

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= IDLE;
			u_q       <= PH_LOAD;
			k_q       <= '0;
			x_q       <= '0;
			y_q       <= '0;
			l_q       <= '0;
			z_q       <= '0;
			lead_q    <= '0;
			pre_cnt   <= '0;
			out_valid <= 1'b0;
			done      <= 1'b0;
		end else begin
			out_valid <= re;
			done      <= (we && last_xy) || ((state == DONE) && out_valid);
			if (adv_xy) begin
				y_q <= y_q + 3'd1; // y fastest, then x, then L.
				if (y_q == 3'd7) begin
					x_q <= x_q + 3'd1;
					if (x_q == 3'd7) begin
						l_q <= l_q + 3'd1;
					end
				end
			end
			if (readback && ((state == PREROLL) || (state == SWEEP))) begin
				lead_q <= lead_last ? 2'd0 : lead_q + 2'd1;
			end
			case (state)
				IDLE: begin
					if (start) begin
						u_q     <= mode;
						k_q     <= k_in;
						x_q     <= '0;
						y_q     <= '0;
						l_q     <= '0;
						lead_q  <= '0;
						pre_cnt <= '0;
						case (mode)
							PH_LOAD, PH_LOAD_ALT: state <= LOAD;
							PH_SHIFT:             state <= SWEEP;
							PH_READ2, PH_READ4:   state <= PREROLL;
							default:              state <= IDLE;
						endcase
					end
				end
				LOAD: begin
					if (we && last_xy) state <= DONE;
				end
				PREROLL: begin
					if (pre_cnt == 3'(`L10_COORD_DELAY - 1)) begin
						state <= SWEEP;
						z_q   <= z_first; // Lines up with the first delayed coordinate.
					end else begin
						pre_cnt <= pre_cnt + 3'd1;
					end
				end
				SWEEP: begin
					if (readback) z_q <= z_next;
					if (sweep_last) state <= DONE;
				end
				DONE: begin
					if (done) state <= IDLE; // Leave after the pulse.
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Delay line for the readback coordinates.
	always_ff @(posedge clk) begin
		x_dly[0] <= x_q;
		y_dly[0] <= y_q;
		for (int i = 1; i < `L10_COORD_DELAY; i++) begin
			x_dly[i] <= x_dly[i-1];
			y_dly[i] <= y_dly[i-1];
		end
	end

	assign s.x      = x_q;
	assign s.y      = y_q;
	assign s.l      = l_q;
	assign s.z      = z_q;
	assign s.k      = k_q;
	assign s.u      = u_q;
	assign s.x_reg5 = x_dly[`L10_COORD_DELAY-1];
	assign s.y_reg5 = y_dly[`L10_COORD_DELAY-1];

endmodule

// File: verilog/layer10_buffer.sv
`timescale 1ns/10ps
`include "layer10_settings.svh"

module layer10_buffer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start,
	input  layer10_pkg::phase_t    mode,
	input  logic [1:0]             k_in,
	input  logic                   pix_valid,
	input  logic [`L10_DATA_W-1:0] pix_data,
	output logic                   busy,
	output logic                   done,
	output logic                   out_valid,
	output logic [`L10_DATA_W-1:0] out_data
);
	import layer10_pkg::*;

	scan_if s_bus ();

	buf_addr_t addr;
	logic      we;
	logic      re;

	tile_scan_ctrl u_ctrl (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.pix_valid (pix_valid),
		.mode      (mode),
		.k_in      (k_in),
		.s         (s_bus.ctrl),
		.we        (we),
		.re        (re),
		.busy      (busy),
		.done      (done),
		.out_valid (out_valid)
	);

	bram1_address_l10 u_agen (
		.s    (s_bus.agen),
		.addr (addr)
	);

	// Read word lands in out_data one cycle after re.
	bram1 u_mem (
		.clk   (clk),
		.we    (we),
		.re    (re),
		.addr  (addr),
		.wdata (pix_data),
		.rdata (out_data)
	);

endmodule

// File: tests/layer10_buffer_monitor.sv
`timescale 1ns/10ps
`include "layer10_settings.svh"

module layer10_buffer_monitor (
	input logic                   clk,
	input logic                   reset,
	input logic                   busy,
	input logic                   done,
	input logic                   out_valid,
	input logic [`L10_DATA_W-1:0] out_data
);

	logic [`L10_DATA_W-1:0] exp_q [$]; // Words still due on out_data.
	logic [`L10_DATA_W-1:0] exp_word;
	int valid_count = 0;
	int done_count = 0;
	int mismatch_count = 0;
	int fault_count = 0;

	task automatic expect_word(input logic [`L10_DATA_W-1:0] w);
		exp_q.push_back(w);
	endtask

	task automatic begin_command();
		valid_count = 0;
		done_count  = 0;
	endtask

	task automatic check_idle();
		if (busy !== 1'b0) begin
			$display("mismatch busy: expected %h, got %h", 1'b0, busy);
			mismatch_count++;
		end
		if (done !== 1'b0) begin
			$display("mismatch done: expected %h, got %h", 1'b0, done);
			mismatch_count++;
		end
	endtask

	// Counts of one command, taken once the DUT is idle again.
	task automatic end_command(input int exp_valid);
		if (valid_count != exp_valid) begin
			$display("mismatch out_valid count: expected %h, got %h", exp_valid, valid_count);
			mismatch_count++;
		end
		if (done_count != 1) begin
			$display("mismatch done count: expected %h, got %h", 1, done_count);
			mismatch_count++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected words were never read back", exp_q.size());
			fault_count++;
			exp_q.delete();
		end
	endtask

	always @(negedge clk) begin
		if (!reset) begin
			if (done) done_count++;
			if (out_valid) begin
				valid_count++;
				if (exp_q.size() == 0) begin
					$display("out_valid arrived when no read was expected");
					fault_count++;
				end else begin
					exp_word = exp_q.pop_front();
					if (out_data !== exp_word) begin
						$display("mismatch out_data: expected %h, got %h", exp_word, out_data);
						mismatch_count++;
					end
				end
			end
		end
	end

endmodule

// File: tests/layer10_buffer_chk.sv
`timescale 1ns/10ps

module layer10_buffer_chk (
	input logic                     clk,
	input logic                     reset,
	input logic                     we,
	input logic                     re,
	input logic                     done,
	input logic                     out_valid,
	input layer10_pkg::ctrl_state_t state
);
	import layer10_pkg::*;

	// Read data trails re by exactly one cycle.
	valid_after_re: assert property (@(posedge clk) disable iff (reset) re |=> out_valid)
		else $error("out_valid did not follow re");

	no_stray_valid: assert property (@(posedge clk) disable iff (reset) !re |=> !out_valid)
		else $error("out_valid without a read one cycle earlier");

	// Load and sweep never overlap.
	no_we_with_re: assert property (@(posedge clk) disable iff (reset) !(we && re))
		else $error("we and re high in the same cycle");

	done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done held for more than one cycle");

	done_in_done_state: assert property (@(posedge clk) disable iff (reset) done |-> (state == DONE))
		else $error("done raised outside the DONE state");

endmodule

// File: tests/layer10_buffer_tb.sv
`timescale 1ns/10ps
`include "layer10_settings.svh"

module layer10_buffer_tb;
	import layer10_pkg::*;

	typedef struct packed {
		phase_t      mode;
		logic [1:0]  k;
		logic [15:0] key; // Mixed into the random pixels of a load.
		logic        poke; // Stray start and pix_valid during the command.
	} cmd_t;

	localparam int NUM_CMDS = 10;
	localparam int DONE_TIMEOUT = 1200;
	localparam int IDLE_TIMEOUT = 8;

	cmd_t cmds [NUM_CMDS] = '{
		'{PH_LOAD,     2'd0, 16'h0000, 1'b0},
		'{PH_READ4,    2'd0, 16'h0000, 1'b0},
		'{PH_READ2,    2'd0, 16'h0000, 1'b0},
		'{PH_SHIFT,    2'd0, 16'h0000, 1'b0}, // Column wraps below zero.
		'{PH_SHIFT,    2'd1, 16'h0000, 1'b0},
		'{PH_SHIFT,    2'd2, 16'h0000, 1'b0},
		'{PH_SHIFT,    2'd3, 16'h0000, 1'b0},
		'{PH_LOAD_ALT, 2'd0, 16'h5a3c, 1'b1},
		'{PH_SHIFT,    2'd1, 16'h0000, 1'b1}, // Must give back the load above.
		'{PH_READ4,    2'd0, 16'h0000, 1'b1}
	};

	logic                   clk;
	logic                   reset;
	logic                   start;
	phase_t                 mode;
	logic [1:0]             k_in;
	logic                   pix_valid;
	logic [`L10_DATA_W-1:0] pix_data;
	logic                   busy;
	logic                   done;
	logic                   out_valid;
	logic [`L10_DATA_W-1:0] out_data;
	logic [`L10_DATA_W-1:0] model [`L10_DEPTH]; // Reference copy of the buffer.
	integer                 seed = 29512;
	int                     timeout_count = 0;

	layer10_buffer UUT (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.mode      (mode),
		.k_in      (k_in),
		.pix_valid (pix_valid),
		.pix_data  (pix_data),
		.busy      (busy),
		.done      (done),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	layer10_buffer_monitor mon (
		.clk       (clk),
		.reset     (reset),
		.busy      (busy),
		.done      (done),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	bind tile_scan_ctrl layer10_buffer_chk u_chk (
		.clk       (clk),
		.reset     (reset),
		.we        (we),
		.re        (re),
		.done      (done),
		.out_valid (out_valid),
		.state     (state)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Row x plus 8 for tiles 4 to 7, column y plus 8 * (L mod 4).
	function automatic buf_addr_t tile_index(input int l, input int x, input int y);
		int row;
		int col;
		row = x + ((l >= 4) ? 8 : 0);
		col = y + 8 * (l % 4);
		return buf_addr_t'(row * 32 + col);
	endfunction

	function automatic buf_addr_t shifted_index(input int l, input int x, input int y,
			input int k);
		int row;
		int col;
		row = x + ((l >= 4) ? 8 : 0);
		col = (y + 8 * (l % 4) + k + 31) % 32; // Adds k - 1 modulo 32.
		return buf_addr_t'(row * 32 + col);
	endfunction

	task automatic queue_reads(input cmd_t c, output int count);
		int steps;
		int off;
		count = 0;
		if (c.mode == PH_SHIFT) begin
			for (int n = 0; n < 512; n++) begin
				mon.expect_word(model[shifted_index(n / 64, (n / 8) % 8, n % 8, int'(c.k))]);
				count++;
			end
		end else if (c.mode == PH_READ2 || c.mode == PH_READ4) begin
			steps = (c.mode == PH_READ4) ? 4 : 2;
			for (int n = 0; n < 64; n++) begin
				for (int j = 0; j < steps; j++) begin
					off = (c.mode == PH_READ4) ? 8 * ((j + 1) % 4) : 8 * j; // 8, 16, 24, 0.
					mon.expect_word(model[buf_addr_t'((n / 8) * 32 + (n % 8) + off)]);
					count++;
				end
			end
		end
	endtask

	task automatic issue_start(input cmd_t c);
		logic [31:0] r;
		r = $random(seed);
		@(posedge clk);
		start     <= 1'b1;
		mode      <= c.mode;
		k_in      <= c.k;
		pix_valid <= c.poke; // Lands in IDLE, so nothing is written.
		pix_data  <= r[15:0];
		@(posedge clk);
		start     <= 1'b0;
		pix_valid <= 1'b0;
	endtask

	// The last pixel stays valid until the wait for done drives the next cycle.
	task automatic stream_pixels(input cmd_t c);
		logic [31:0] r;
		int gap;
		for (int n = 0; n < 512; n++) begin
			r = $random(seed);
			gap = $unsigned(r) % 3;
			repeat (gap) begin
				@(posedge clk);
				pix_valid <= 1'b0;
				start     <= 1'b0;
			end
			r = $random(seed);
			@(posedge clk);
			pix_valid <= 1'b1;
			pix_data  <= r[15:0] ^ c.key;
			start     <= c.poke && (n == 100); // Start while busy.
			if (c.poke && n == 100) mode <= PH_SHIFT;
			model[tile_index(n / 64, (n / 8) % 8, n % 8)] = r[15:0] ^ c.key;
		end
	endtask

	task automatic wait_done(input logic poke, output logic ok);
		logic [31:0] r;
		ok = 1'b0;
		for (int cyc = 0; cyc < DONE_TIMEOUT && !ok; cyc++) begin
			r = $random(seed);
			@(posedge clk);
			pix_valid <= poke;
			pix_data  <= r[15:0];
			start     <= poke && (cyc == 20);
			if (poke && cyc == 20) mode <= PH_LOAD;
			@(negedge clk);
			ok = done;
		end
	endtask

	task automatic wait_idle(output logic ok);
		ok = 1'b0;
		for (int cyc = 0; cyc < IDLE_TIMEOUT && !ok; cyc++) begin
			@(posedge clk);
			pix_valid <= 1'b0;
			start     <= 1'b0;
			@(negedge clk);
			ok = !busy;
		end
	endtask

	initial begin
		logic ok;
		int reads;
		reset     = 1'b1;
		start     = 1'b0;
		mode      = PH_LOAD;
		k_in      = 2'd0;
		pix_valid = 1'b0;
		pix_data  = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		mon.check_idle();
		for (int i = 0; i < NUM_CMDS && timeout_count == 0; i++) begin
			mon.begin_command();
			queue_reads(cmds[i], reads);
			issue_start(cmds[i]);
			if (cmds[i].mode == PH_LOAD || cmds[i].mode == PH_LOAD_ALT) stream_pixels(cmds[i]);
			wait_done(cmds[i].poke, ok);
			if (ok) wait_idle(ok);
			if (ok) begin
				mon.end_command(reads);
			end else begin
				$display("timeout on command %0d, the DUT did not finish", i);
				timeout_count++;
			end
		end
		$display("errors: %0d mismatches, %0d faults, %0d timeouts",
			mon.mismatch_count, mon.fault_count, timeout_count);
		if (mon.mismatch_count == 0 && mon.fault_count == 0 && timeout_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: layer10_buffer.f
+incdir+include
verilog/layer10_pkg.sv
verilog/scan_if.sv
verilog/bram1_address_l10.sv
verilog/bram1.sv
verilog/tile_scan_ctrl.sv
verilog/layer10_buffer.sv
tests/layer10_buffer_monitor.sv
tests/layer10_buffer_chk.sv
tests/layer10_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module layer10_buffer_tb -f layer10_buffer.f \
	-Mdir obj_dir -o layer10_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/layer10_sim > sim.log 2>&1

grep -q "Regression passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
